// ==== project.f ====
verilog/kalmanPkg.sv
verilog/measurementCapture.sv
verilog/matVecUnit.sv
verilog/filterSequencer.sv
verilog/estimatePort.sv
verilog/kalmanTop.sv
bench/kalman_properties.sv
bench/kalmanTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= kalmanTb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIMARGS   ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJDIR VFLAGS SIMARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(SIMARGS)

clean:
	rm -rf $(OBJDIR)

// ==== bench/kalmanTb.sv ====
module kalmanTb
    import kalmanPkg::*;
();

    localparam int stepsPerPhase = 10;
    localparam int phaseCount = 4;
    localparam int cycleLimit = phaseCount * (stepsPerPhase * stepCycles + 15);

    logic        clk;
    logic        rst;
    stepIndex_t  n;
    fix_t        u;
    vec2_t       z;
    vec2_t       x0;
    mat22_t      F;
    vec2_t       B;
    mat22_t      H;
    mat22_t      K;
    vec2_t       xo;
    stepIndex_t  no;
    logic        outen;
    logic [31:0] rngState = 32'h734a;
    int          cycles = 0;

    kalmanTop uut (
        .clk   (clk),
        .rst   (rst),
        .n     (n),
        .u     (u),
        .z     (z),
        .x0    (x0),
        .F     (F),
        .B     (B),
        .H     (H),
        .K     (K),
        .xo    (xo),
        .no    (no),
        .outen (outen)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    // signed value in (-span, span).
    function automatic fix_t randFix(input int span);
        rngState = xorshift(rngState);
        return fix_t'(int'($signed(rngState[15:0])) % span);
    endfunction

    function automatic mat22_t randMat(input int span);
        mat22_t m;
        m.a00 = randFix(span);
        m.a01 = randFix(span);
        m.a10 = randFix(span);
        m.a11 = randFix(span);
        return m;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic loadParams(input int phase);
        F = randMat(20);
        B.e0 = randFix(24);
        B.e1 = randFix(24);
        H = randMat(20);
        K = '0;                                    // prediction only.
        x0.e0 = randFix(64);
        x0.e1 = randFix(64);
        if (phase == 0) begin
            F = {16'sd16, 16'sd0, 16'sd8, 16'sd16};    // position plus half velocity.
        end else if (phase > 1) begin
            K = randMat(6 * phase);
        end
    endtask

    task automatic drawInputs(input int phase);
        int span;
        span = (phase == 3) ? 400 : 48;            // wider swings at the end.
        rngState = xorshift(rngState);
        n = rngState[31:16];
        u = randFix(span);
        z.e0 = randFix(span);
        z.e1 = randFix(span);
    endtask

    task automatic runPhase(input int phase);
        int pulses;
        pulses = 0;
        @(posedge clk);
        #2;
        rst = 1'b0;
        loadParams(phase);                         // only while reset is low.
        drawInputs(phase);
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b1;
        while (pulses < stepsPerPhase) begin
            @(posedge clk);
            #2;
            if (outen) begin
                pulses++;
                drawInputs(phase);                 // held for the next step.
            end
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycleLimit) begin
            abortRun("timeout with filter steps still pending");
        end else if (uut.props.failed) begin
            abortRun("a property check failed, see the error above");
        end
    end

    initial begin
        rst = 1'b0;
        n = '0;
        u = '0;
        z = '0;
        x0 = '0;
        F = '0;
        B = '0;
        H = '0;
        K = '0;
        for (int phase = 0; phase < phaseCount; phase++) begin
            runPhase(phase);
        end
        @(posedge clk);
        #2;
        if (uut.props.failed) begin
            abortRun("a property check failed, see the error above");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// ==== bench/kalman_properties.sv ====
module kalman_properties
    import kalmanPkg::*;
(
    input logic       clk,
    input logic       rst,
    input stepIndex_t n,
    input fix_t       u,
    input vec2_t      z,
    input vec2_t      x0,
    input mat22_t     F,
    input vec2_t      B,
    input mat22_t     H,
    input mat22_t     K,
    input vec2_t      xo,
    input stepIndex_t no,
    input logic       outen
);

    int         cycleCount;                        // edges since reset release.
    vec2_t      xPlusModel;
    vec2_t      expXo;
    stepIndex_t expNo;
    logic       pulseDue;
    logic       failed = 1'b0;

    function automatic fix_t mulFix(input fix_t a, input fix_t b);
        logic signed [31:0] full;
        full = 32'(a) * 32'(b);
        return fix_t'(full >>> fracBits);          // arithmetic shift then keep low 16.
    endfunction

    function automatic vec2_t rowSums(input mat22_t m, input vec2_t v);
        vec2_t r;
        r.e0 = mulFix(m.a00, v.e0) + mulFix(m.a01, v.e1);
        r.e1 = mulFix(m.a10, v.e0) + mulFix(m.a11, v.e1);
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // shadow filter stepping once per sample edge
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk or negedge rst) begin : shadowStep
        vec2_t xm;
        vec2_t y;
        vec2_t ky;
        if (!rst) begin
            cycleCount <= 0;
            xPlusModel <= x0;
            expXo      <= '0;
            expNo      <= '0;
        end else begin
            cycleCount <= cycleCount + 1;
            if (cycleCount % stepCycles == 0) begin    // the DUT samples here.
                xm = rowSums(F, xPlusModel);
                xm.e0 = xm.e0 + mulFix(B.e0, u);
                xm.e1 = xm.e1 + mulFix(B.e1, u);
                y = rowSums(H, xm);
                y.e0 = z.e0 - y.e0;                // residual.
                y.e1 = z.e1 - y.e1;
                ky = rowSums(K, y);
                xPlusModel.e0 <= xm.e0 + ky.e0;
                xPlusModel.e1 <= xm.e1 + ky.e1;
                expXo <= xm;
                expNo <= n;
            end
        end
    end

    assign pulseDue = cycleCount >= stepCycles && cycleCount % stepCycles == 0;

    assert property (@(posedge clk) (!rst || !$past(rst)) |-> !outen)
        else begin
            failed = 1'b1;
            $error("mismatch at %0t: outen expected 0 got %b", $time, $sampled(outen));
        end

    assert property (@(posedge clk) (!rst || !$past(rst)) |-> xo == '0)
        else begin
            failed = 1'b1;
            $error("mismatch at %0t: xo expected 0 got %h", $time, $sampled(xo));
        end

    assert property (@(posedge clk) (!rst || !$past(rst)) |-> no == '0)
        else begin
            failed = 1'b1;
            $error("mismatch at %0t: no expected 0 got %h", $time, $sampled(no));
        end

    assert property (@(posedge clk) disable iff (!rst) outen == pulseDue)
        else begin
            failed = 1'b1;
            $error("mismatch at %0t: outen expected %b got %b", $time,
                $sampled(pulseDue), $sampled(outen));
        end

    assert property (@(posedge clk) disable iff (!rst) outen |-> xo == expXo)
        else begin
            failed = 1'b1;
            $error("mismatch at %0t: xo expected %h got %h", $time,
                $sampled(expXo), $sampled(xo));
        end

    assert property (@(posedge clk) disable iff (!rst) outen |-> no == expNo)
        else begin
            failed = 1'b1;
            $error("mismatch at %0t: no expected %h got %h", $time,
                $sampled(expNo), $sampled(no));
        end

    assert property (@(posedge clk) disable iff (!rst) !outen |-> $stable(xo) && $stable(no))
        else begin
            failed = 1'b1;
            $error("xo or no changed at %0t while outen was low", $time);
        end

endmodule

bind kalmanTop kalman_properties props (.*);

// ==== verilog/kalmanTop.sv ====
module kalmanTop
    import kalmanPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  stepIndex_t n,
    input  fix_t       u,
    input  vec2_t      z,
    input  vec2_t      x0,
    input  mat22_t     F,
    input  vec2_t      B,
    input  mat22_t     H,
    input  mat22_t     K,
    output vec2_t      xo,
    output stepIndex_t no,
    output logic       outen
);

    sample_t sample;
    logic    sampleStrobe;
    logic    opLoad;
    mat22_t  opMat;
    vec2_t   opVec;
    vec2_t   product;
    vec2_t   xMinus;
    logic    publish;

    measurementCapture capture (
        .clk          (clk),
        .rst          (rst),
        .sampleStrobe (sampleStrobe),
        .n            (n),
        .u            (u),
        .z            (z),
        .sample       (sample)
    );

    matVecUnit mul (
        .clk     (clk),
        .rst     (rst),
        .opLoad  (opLoad),
        .opMat   (opMat),
        .opVec   (opVec),
        .product (product)
    );

    filterSequencer seq (
        .clk          (clk),
        .rst          (rst),
        .sample       (sample),
        .F            (F),
        .B            (B),
        .H            (H),
        .K            (K),
        .x0           (x0),
        .sampleStrobe (sampleStrobe),
        .opLoad       (opLoad),
        .opMat        (opMat),
        .opVec        (opVec),
        .xMinus       (xMinus),
        .publish      (publish),
        .product      (product)
    );

    estimatePort port (
        .clk     (clk),
        .rst     (rst),
        .publish (publish),
        .xMinus  (xMinus),
        .index   (sample.index),               // straight from the capture.
        .xo      (xo),
        .no      (no),
        .outen   (outen)
    );

endmodule

// ==== verilog/estimatePort.sv ====
module estimatePort
    import kalmanPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       publish,
    input  vec2_t      xMinus,
    input  stepIndex_t index,
    output vec2_t      xo,
    output stepIndex_t no,
    output logic       outen
);

    // outputs hold between pulses.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            xo    <= '0;
            no    <= '0;
            outen <= 1'b0;
        end else begin
            outen <= publish;                      // one-cycle pulse.
            if (publish) begin
                xo <= xMinus;                      // predicted state.
                no <= index;
            end
        end
    end

endmodule

// ==== verilog/filterSequencer.sv ====
module filterSequencer
    import kalmanPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  sample_t sample,
    input  mat22_t  F,
    input  vec2_t   B,
    input  mat22_t  H,
    input  mat22_t  K,
    input  vec2_t   x0,
    output logic    sampleStrobe,
    output logic    opLoad,
    output mat22_t  opMat,
    output vec2_t   opVec,
    output vec2_t   xMinus,
    output logic    publish,
    input  vec2_t   product
);

    stepState_t state;
    stepState_t nextState;
    vec2_t      yReg;                              // residual z - H x-.
    vec2_t      xPlus;                             // corrected state.
    mat22_t     bMat;                              // B as left column.
    vec2_t      uVec;                              // (u, 0).

    ////////////////////////////////////////////////////////////////////////////
    // step state machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (state == outSt) begin
            nextState = sampleSt;                  // wrap to a fresh sample.
        end else begin
            nextState = stepState_t'(state + 4'd1);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= sampleSt;
            xPlus <= x0;                           // initial estimate.
        end else begin
            state <= nextState;
            if (state == storeX) begin
                xPlus.e0 <= xMinus.e0 + product.e0;    // x+ = x- + K y.
                xPlus.e1 <= xMinus.e1 + product.e1;
            end
        end
    end

    assign sampleStrobe = (state == sampleSt);
    assign publish      = (state == outSt);

    ////////////////////////////////////////////////////////////////////////////
    // operand routing to the shared multiplier
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        bMat     = '0;
        bMat.a00 = B.e0;
        bMat.a10 = B.e1;
        uVec     = '0;
        uVec.e0  = sample.accel;
    end

    always_comb begin
        opLoad = 1'b0;
        opMat  = '0;
        opVec  = '0;
        case (state)
            loadFx: begin
                opLoad = 1'b1;
                opMat  = F;
                opVec  = xPlus;
            end
            loadBu: begin
                opLoad = 1'b1;
                opMat  = bMat;
                opVec  = uVec;
            end
            loadHx: begin
                opLoad = 1'b1;
                opMat  = H;
                opVec  = xMinus;
            end
            loadKy: begin
                opLoad = 1'b1;
                opMat  = K;
                opVec  = yReg;
            end
            default: begin
            end
        endcase
    end

    // accumulators follow the product one cycle after each load.
    always_ff @(posedge clk) begin
        case (state)
            loadBu: begin
                xMinus <= product;                 // F x+.
            end
            addBu: begin
                xMinus.e0 <= xMinus.e0 + product.e0;    // plus B u.
                xMinus.e1 <= xMinus.e1 + product.e1;
            end
            storeY: begin
                yReg.e0 <= sample.meas.e0 - product.e0;
                yReg.e1 <= sample.meas.e1 - product.e1;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== verilog/matVecUnit.sv ====
module matVecUnit
    import kalmanPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   opLoad,
    input  mat22_t opMat,
    input  vec2_t  opVec,
    output vec2_t  product
);

    mat22_t matReg;
    vec2_t  vecReg;

    // full signed product shifted by the fraction bits and cut to 16.
    function automatic fix_t fixMul(input fix_t a, input fix_t b);
        logic signed [2*fixWidth-1:0] full;
        full = (2*fixWidth)'(a) * (2*fixWidth)'(b);
        return full[fracBits +: fixWidth];
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            matReg <= '0;
            vecReg <= '0;
        end else if (opLoad) begin
            matReg <= opMat;
            vecReg <= opVec;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // row sums wrap at the sample width
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        product.e0 = fixMul(matReg.a00, vecReg.e0) + fixMul(matReg.a01, vecReg.e1);
        product.e1 = fixMul(matReg.a10, vecReg.e0) + fixMul(matReg.a11, vecReg.e1);
    end

endmodule

// ==== verilog/measurementCapture.sv ====
module measurementCapture
    import kalmanPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       sampleStrobe,
    input  stepIndex_t n,
    input  fix_t       u,
    input  vec2_t      z,
    output sample_t    sample
);

    // one consistent snapshot per step, whatever the inputs do meanwhile.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sample <= '0;
        end else if (sampleStrobe) begin
            sample.index <= n;                     // index rides to the output.
            sample.accel <= u;
            sample.meas  <= z;
        end
    end

endmodule

// ==== verilog/kalmanPkg.sv ====
package kalmanPkg;

    ////////////////////////////////////////////////////////////////////////////
    // fixed-point format
    ////////////////////////////////////////////////////////////////////////////

    localparam int fixWidth = 16;                  // sample width.
    localparam int fracBits = 4;                   // fraction bits.
    localparam int stepCycles = 9;                 // cycles per filter step.

    typedef logic signed [fixWidth-1:0] fix_t;
    typedef logic [15:0] stepIndex_t;

    // element 0 sits in the low bits.
    typedef struct packed {
        fix_t e1;
        fix_t e0;
    } vec2_t;

    // row-major 2x2 with a00 in the low bits.
    typedef struct packed {
        fix_t a11;
        fix_t a10;
        fix_t a01;
        fix_t a00;
    } mat22_t;

    typedef struct packed {
        stepIndex_t index;                         // sample index n.
        fix_t accel;                               // scalar input u.
        vec2_t meas;                               // measurement z.
    } sample_t;

    typedef enum logic [3:0] {
        sampleSt,
        loadFx,
        loadBu,
        addBu,
        loadHx,
        storeY,
        loadKy,
        storeX,
        outSt
    } stepState_t;

endpackage
